// ==== filelist.f ====
hw/avmm_pkg.sv
hw/mem_map_pkg.sv
hw/avmm_reg_stage.sv
hw/avmm_rr_arbiter.sv
hw/avmm_mem_slave.sv
hw/avmm_mem_subsystem_top.sv
tests/tb_mem_subsystem.sv

// ==== tests/tb_mem_subsystem.sv ====
// Testbench of the shared-memory subsystem
// Clock, reset, two master drivers and a shadow memory with a byte-merge reference
// A comparing process checks every read response against the per-master expected queue
// A fairness monitor and a cycle counter guard arbitration and run length

`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsystem;
    import avmm_pkg::*;
    import mem_map_pkg::*;

    localparam logic [31:0] SEED = 32'hc60c286f;
    localparam int N_RANDOM_OPS = 200;
    // Each request costs about SERVICE_INTERVAL cycles at the slave, so 50 per request is ample
    localparam int MAX_CYCLES = 50 * N_MASTERS * N_RANDOM_OPS;
    // Reads still in flight once the masters stop drain well within this many cycles
    localparam int DRAIN_LIMIT = 10 * SERVICE_INTERVAL * (REQ_QUEUE_DEPTH + 2 * REG_STAGES);

    logic                                  mem_slave;
    logic                                  reset;
    logic [N_MASTERS-1:0]                  m_read;
    logic [N_MASTERS-1:0]                  m_write;
    logic [N_MASTERS-1:0][ADDR_WIDTH-1:0]  m_address;
    logic [N_MASTERS-1:0][DATA_WIDTH-1:0]  m_writedata;
    logic [N_MASTERS-1:0][BE_WIDTH-1:0]    m_byteenable;
    logic [N_MASTERS-1:0]                  m_waitrequest;
    logic [N_MASTERS-1:0][DATA_WIDTH-1:0]  m_readdata;
    logic [N_MASTERS-1:0]                  m_readdatavalid;

    // Shadow of the memory contents and the reads still owed to each master
    logic [DATA_WIDTH-1:0] shadow [MEM_DEPTH];
    logic [DATA_WIDTH-1:0] exp_q0 [$];
    logic [DATA_WIDTH-1:0] exp_q1 [$];
    int                    reads_accepted [N_MASTERS];
    int                    responses [N_MASTERS];
    int                    starve [N_MASTERS];
    int                    stall_cycles;
    int                    cycle_count;
    int                    first_waits;

    avmm_mem_subsystem_top uut
    (
        .mem_slave(mem_slave),
        .reset(reset),
        .m_read(m_read),
        .m_write(m_write),
        .m_address(m_address),
        .m_writedata(m_writedata),
        .m_byteenable(m_byteenable),
        .m_waitrequest(m_waitrequest),
        .m_readdata(m_readdata),
        .m_readdatavalid(m_readdatavalid)
    );

    initial
    begin
        mem_slave = 1'b0;
        forever #20 mem_slave = ~mem_slave;
    end

    task automatic stop_on_error();
        $display("Errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    // Reference model of a write: only enabled byte lanes take the new data
    function automatic logic [DATA_WIDTH-1:0] merge_bytes(input logic [DATA_WIDTH-1:0] old,
                                                          input logic [DATA_WIDTH-1:0] data,
                                                          input logic [BE_WIDTH-1:0] be);
        logic [DATA_WIDTH-1:0] result;
        result = old;
        for (int b = 0; b < BE_WIDTH; b++)
            if (be[b])
                result[8*b +: 8] = data[8*b +: 8];
        return result;
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int expected_count(input int idx);
        return (idx == 0) ? exp_q0.size() : exp_q1.size();
    endfunction

    function automatic logic [DATA_WIDTH-1:0] pop_expected(input int idx);
        if (idx == 0)
            return exp_q0.pop_front();
        return exp_q1.pop_front();
    endfunction

    // Called on a falling edge; holds the request until accepted, returns on the next one
    task automatic issue(input int idx, input logic is_write, input logic [ADDR_WIDTH-1:0] addr,
                         input logic [DATA_WIDTH-1:0] data, input logic [BE_WIDTH-1:0] be,
                         output int waits);
        waits = 0;
        m_read[idx] = !is_write;
        m_write[idx] = is_write;
        m_address[idx] = addr;
        m_writedata[idx] = data;
        m_byteenable[idx] = be;
        #1;
        while (m_waitrequest[idx])
        begin
            waits++;
            @(negedge mem_slave);
            #1;
        end
        // Accepted at the coming rising edge, so the shadow moves now
        if (is_write)
            shadow[addr] = merge_bytes(shadow[addr], data, be);
        else
        begin
            if (idx == 0)
                exp_q0.push_back(shadow[addr]);
            else
                exp_q1.push_back(shadow[addr]);
            reads_accepted[idx]++;
        end
        @(negedge mem_slave);
    endtask

    task automatic release_bus(input int idx);
        m_read[idx] = 1'b0;
        m_write[idx] = 1'b0;
    endtask

    // The top address bit keeps each master's back-to-back random requests in its own half
    task automatic run_random(input int idx, input int n_ops);
        logic [31:0]           state;
        logic                  is_write;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
        logic [BE_WIDTH-1:0]   be;
        int                    waits;
        state = SEED ^ (idx * 32'h9e3779b9);
        for (int n = 0; n < n_ops; n++)
        begin
            state = lcg_next(state);
            is_write = state[20];
            addr = {1'(idx), state[31 -: ADDR_WIDTH-1]};
            state = lcg_next(state);
            data = state;
            state = lcg_next(state);
            be = is_write ? state[31 -: BE_WIDTH] : '1;
            issue(idx, is_write, addr, data, be, waits);
        end
        release_bus(idx);
    endtask

    task automatic check_quiet();
        assert (m_waitrequest == '1)
        else
        begin
            $display("[FAIL] m_waitrequest got %h expected %h", m_waitrequest, {N_MASTERS{1'b1}});
            stop_on_error();
        end
        assert (m_readdatavalid == '0)
        else
        begin
            $display("[FAIL] m_readdatavalid got %h expected %h", m_readdatavalid, 0);
            stop_on_error();
        end
    endtask

    // Responses are compared on the falling edge, where they are stable
    always @(negedge mem_slave)
    begin
        logic [DATA_WIDTH-1:0] want;
        for (int i = 0; i < N_MASTERS; i++)
        begin
            if (!reset && m_readdatavalid[i])
            begin
                assert (expected_count(i) != 0)
                else
                begin
                    $display("Master %0d got a read response with no read outstanding", i);
                    stop_on_error();
                end
                want = pop_expected(i);
                assert (m_readdata[i] === want)
                else
                begin
                    $display("[FAIL] m_readdata[%0d] got %h expected %h", i, m_readdata[i], want);
                    stop_on_error();
                end
                responses[i]++;
            end
        end
    end

    // A waiting master may see at most N_MASTERS accepts of the other before its own
    // A cycle where somebody requests and nobody is accepted is memory back-pressure
    always @(negedge mem_slave)
    begin
        logic [N_MASTERS-1:0] req;
        logic [N_MASTERS-1:0] acc;
        #2;
        req = m_read | m_write;
        acc = req & ~m_waitrequest;
        if (!reset && req != '0 && acc == '0)
            stall_cycles++;
        for (int i = 0; i < N_MASTERS; i++)
        begin
            if (reset || acc[i] || !req[i])
                starve[i] = 0;
            else if (acc != '0)
                starve[i]++;
            assert (starve[i] <= N_MASTERS)
            else
            begin
                $display("Master %0d waited through %0d grants of the other master", i, starve[i]);
                stop_on_error();
            end
        end
    end

    always @(posedge mem_slave)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stop_on_error();
        end
    end

    initial
    begin
        int waits;
        int drain;
        reset = 1'b1;
        // Both masters hold a read through reset, which must stall on the waitrequest pipe
        m_read = '1;
        m_write = '0;
        m_address = '0;
        m_writedata = '0;
        m_byteenable = '0;
        cycle_count = 0;
        stall_cycles = 0;
        for (int a = 0; a < MEM_DEPTH; a++)
            shadow[a] = '0;
        for (int i = 0; i < N_MASTERS; i++)
        begin
            reads_accepted[i] = 0;
            responses[i] = 0;
            starve[i] = 0;
        end

        // Outputs must stay quiet through the two reset cycles
        repeat (2)
        begin
            @(negedge mem_slave);
            check_quiet();
        end
        reset = 1'b0;
        @(negedge mem_slave);
        check_quiet();
        release_bus(1);

        // The first write must stall while the waitrequest pipe still holds ones
        issue(0, 1'b1, 6'd5, 32'h1234_5678, 4'hf, first_waits);
        assert (first_waits > 0)
        else
        begin
            $display("Master 0 was accepted before the waitrequest pipe drained");
            stop_on_error();
        end
        issue(0, 1'b0, 6'd5, '0, '1, waits);
        issue(0, 1'b0, 6'd10, '0, '1, waits);
        // Partial byte enables merge into the word written above
        issue(0, 1'b1, 6'd5, 32'haabb_ccdd, 4'b0101, waits);
        issue(0, 1'b0, 6'd5, '0, '1, waits);
        issue(0, 1'b1, 6'd7, 32'hffee_ddcc, 4'b1000, waits);
        issue(0, 1'b0, 6'd7, '0, '1, waits);
        release_bus(0);
        issue(1, 1'b1, 6'd40, 32'h0bad_f00d, 4'b0110, waits);
        issue(1, 1'b0, 6'd40, '0, '1, waits);
        release_bus(1);

        stall_cycles = 0;
        fork
            run_random(0, N_RANDOM_OPS);
            run_random(1, N_RANDOM_OPS);
        join

        drain = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && drain < DRAIN_LIMIT)
        begin
            @(negedge mem_slave);
            drain++;
        end
        // Extra cycles would expose any response that nobody asked for
        repeat (20) @(negedge mem_slave);

        assert (stall_cycles > 0)
        else
        begin
            $display("Random traffic never met waitrequest back-pressure");
            stop_on_error();
        end
        for (int i = 0; i < N_MASTERS; i++)
        begin
            assert (responses[i] == reads_accepted[i])
            else
            begin
                $display("[FAIL] responses[%0d] got %h expected %h", i, responses[i],
                         reads_accepted[i]);
                stop_on_error();
            end
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hw/avmm_mem_subsystem_top.sv ====
// Top level of the shared-memory subsystem
// Peer masters go through the round-robin arbiter, then the register
// stage, then reach the word memory slave

`timescale 1ns/1ps
`default_nettype none

module avmm_mem_subsystem_top
(
    input  logic                                                   mem_slave,
    input  logic                                                   reset,
    input  logic [avmm_pkg::N_MASTERS-1:0]                         m_read,
    input  logic [avmm_pkg::N_MASTERS-1:0]                         m_write,
    input  logic [avmm_pkg::N_MASTERS-1:0][avmm_pkg::ADDR_WIDTH-1:0] m_address,
    input  logic [avmm_pkg::N_MASTERS-1:0][avmm_pkg::DATA_WIDTH-1:0] m_writedata,
    input  logic [avmm_pkg::N_MASTERS-1:0][avmm_pkg::BE_WIDTH-1:0]   m_byteenable,
    output logic [avmm_pkg::N_MASTERS-1:0]                         m_waitrequest,
    output logic [avmm_pkg::N_MASTERS-1:0][avmm_pkg::DATA_WIDTH-1:0] m_readdata,
    output logic [avmm_pkg::N_MASTERS-1:0]                         m_readdatavalid
);
    import avmm_pkg::*;
    import mem_map_pkg::*;

    // Arbiter to register stage
    logic                  up_read;
    logic                  up_write;
    logic [ADDR_WIDTH-1:0] up_address;
    logic [DATA_WIDTH-1:0] up_writedata;
    logic [BE_WIDTH-1:0]   up_byteenable;
    logic                  up_waitrequest;
    logic [DATA_WIDTH-1:0] up_readdata;
    logic                  up_readdatavalid;

    // Register stage to memory slave
    logic                  dn_read;
    logic                  dn_write;
    logic [ADDR_WIDTH-1:0] dn_address;
    logic [DATA_WIDTH-1:0] dn_writedata;
    logic [BE_WIDTH-1:0]   dn_byteenable;
    logic                  dn_waitrequest;
    logic [DATA_WIDTH-1:0] dn_readdata;
    logic                  dn_readdatavalid;

    avmm_rr_arbiter u_arbiter (.*);

    // Stage counts must stay within the slave's skid room
    avmm_reg_stage
    #(
        .N_REG_STAGES(REG_STAGES),
        .N_WAITREQUEST_STAGES(WAITREQUEST_STAGES)
    )
    u_reg_stage (.*);

    avmm_mem_slave u_mem (.*);

endmodule

`default_nettype wire

// ==== hw/avmm_mem_slave.sv ====
// Word memory slave at the end of the subsystem
// Every request strobe is pushed into a queue in the cycle it arrives
// The queue head is served at most once per SERVICE_INTERVAL cycles
// Waitrequest rises while fewer than REQ_SKID entries are free

`timescale 1ns/1ps
`default_nettype none

module avmm_mem_slave
(
    input  logic                            mem_slave,
    input  logic                            reset,
    input  logic                            dn_read,
    input  logic                            dn_write,
    input  logic [avmm_pkg::ADDR_WIDTH-1:0] dn_address,
    input  logic [avmm_pkg::DATA_WIDTH-1:0] dn_writedata,
    input  logic [avmm_pkg::BE_WIDTH-1:0]   dn_byteenable,
    output logic                            dn_waitrequest,
    output logic [avmm_pkg::DATA_WIDTH-1:0] dn_readdata,
    output logic                            dn_readdatavalid
);
    import avmm_pkg::*;
    import mem_map_pkg::*;

    localparam int PTR_W = $clog2(REQ_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(REQ_QUEUE_DEPTH + 1);
    localparam int PACE_W = $clog2(SERVICE_INTERVAL + 1);

    logic                  q_write [REQ_QUEUE_DEPTH];
    logic [ADDR_WIDTH-1:0] q_addr [REQ_QUEUE_DEPTH];
    logic [DATA_WIDTH-1:0] q_data [REQ_QUEUE_DEPTH];
    logic [BE_WIDTH-1:0]   q_be [REQ_QUEUE_DEPTH];
    logic [DATA_WIDTH-1:0] mem [MEM_DEPTH];
    logic [PTR_W-1:0]      wr_ptr;
    logic [PTR_W-1:0]      rd_ptr;
    logic [CNT_W-1:0]      count;
    logic [CNT_W-1:0]      count_next;
    logic [PACE_W-1:0]     pace;
    logic                  push;
    logic                  pop;

    // Strobes are taken unconditionally because waitrequest is only a hint
    assign push = dn_read || dn_write;
    assign pop = (count != '0) && (pace == '0);
    assign count_next = count + CNT_W'(push) - CNT_W'(pop);

    always_ff @(posedge mem_slave)
    begin
        if (push)
        begin
            q_write[wr_ptr] <= dn_write;
            q_addr[wr_ptr] <= dn_address;
            q_data[wr_ptr] <= dn_writedata;
            q_be[wr_ptr] <= dn_byteenable;
        end
    end

    always_ff @(posedge mem_slave)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            pace <= '0;
            dn_waitrequest <= 1'b1;
            dn_readdatavalid <= 1'b0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == PTR_W'(REQ_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(REQ_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count_next;
            // The pace counter holds off the next pop after each service
            if (pop)
                pace <= PACE_W'(SERVICE_INTERVAL - 1);
            else if (pace != '0)
                pace <= pace - 1'b1;
            // Built from the next count, so it tracks the queue without lag
            dn_waitrequest <= (REQ_QUEUE_DEPTH - int'(count_next)) < REQ_SKID;
            dn_readdatavalid <= pop && !q_write[rd_ptr];
        end
    end

    // Writes merge only the enabled byte lanes into the stored word
    always_ff @(posedge mem_slave)
    begin
        if (reset)
        begin
            for (int i = 0; i < MEM_DEPTH; i++)
                mem[i] <= '0;
        end
        else if (pop && q_write[rd_ptr])
        begin
            for (int b = 0; b < BE_WIDTH; b++)
            begin
                if (q_be[rd_ptr][b])
                    mem[q_addr[rd_ptr]][8*b +: 8] <= q_data[rd_ptr][8*b +: 8];
            end
        end
    end

    always_ff @(posedge mem_slave)
    begin
        if (pop)
            dn_readdata <= mem[q_addr[rd_ptr]];
    end

    // The skid room upstream must be large enough that this never fires
    a_no_push_full: assert property (@(posedge mem_slave) disable iff (reset)
        push |-> (count != CNT_W'(REQ_QUEUE_DEPTH)));

endmodule

`default_nettype wire

// ==== hw/avmm_rr_arbiter.sv ====
// Round-robin arbiter of the peer masters onto one bus
// One requesting master is granted per cycle, priority rotates on accept
// A FIFO of master indices steers each read response back to its issuer

`timescale 1ns/1ps
`default_nettype none

module avmm_rr_arbiter
(
    input  logic                                                   mem_slave,
    input  logic                                                   reset,
    input  logic [avmm_pkg::N_MASTERS-1:0]                         m_read,
    input  logic [avmm_pkg::N_MASTERS-1:0]                         m_write,
    input  logic [avmm_pkg::N_MASTERS-1:0][avmm_pkg::ADDR_WIDTH-1:0] m_address,
    input  logic [avmm_pkg::N_MASTERS-1:0][avmm_pkg::DATA_WIDTH-1:0] m_writedata,
    input  logic [avmm_pkg::N_MASTERS-1:0][avmm_pkg::BE_WIDTH-1:0]   m_byteenable,
    output logic [avmm_pkg::N_MASTERS-1:0]                         m_waitrequest,
    output logic [avmm_pkg::N_MASTERS-1:0][avmm_pkg::DATA_WIDTH-1:0] m_readdata,
    output logic [avmm_pkg::N_MASTERS-1:0]                         m_readdatavalid,
    output logic                                                   up_read,
    output logic                                                   up_write,
    output logic [avmm_pkg::ADDR_WIDTH-1:0]                        up_address,
    output logic [avmm_pkg::DATA_WIDTH-1:0]                        up_writedata,
    output logic [avmm_pkg::BE_WIDTH-1:0]                          up_byteenable,
    input  logic                                                   up_waitrequest,
    input  logic [avmm_pkg::DATA_WIDTH-1:0]                        up_readdata,
    input  logic                                                   up_readdatavalid
);
    import avmm_pkg::*;
    import mem_map_pkg::*;

    localparam int ID_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;
    localparam int PTR_W = (RESP_ID_DEPTH > 1) ? $clog2(RESP_ID_DEPTH) : 1;
    localparam int CNT_W = $clog2(RESP_ID_DEPTH + 1);

    logic [N_MASTERS-1:0] m_req;
    logic [ID_W-1:0]      prio;
    logic [ID_W-1:0]      gnt;
    logic                 gnt_valid;
    logic                 accept;
    logic [ID_W-1:0]      id_mem [RESP_ID_DEPTH];
    logic [PTR_W-1:0]     id_wr_ptr;
    logic [PTR_W-1:0]     id_rd_ptr;
    logic [CNT_W-1:0]     id_count;
    logic [ID_W-1:0]      id_head;
    logic                 id_push;
    logic                 id_pop;

    assign m_req = m_read | m_write;

    // Scan from the lowest priority up, so the master holding priority wins last
    always_comb
    begin
        gnt = prio;
        gnt_valid = 1'b0;
        for (int i = N_MASTERS - 1; i >= 0; i--)
        begin
            if (m_req[(int'(prio) + i) % N_MASTERS])
            begin
                gnt = ID_W'((int'(prio) + i) % N_MASTERS);
                gnt_valid = 1'b1;
            end
        end
    end

    // The register stage takes the request only while up_waitrequest is low
    assign accept = gnt_valid && !up_waitrequest;

    assign up_read = gnt_valid && m_read[gnt];
    assign up_write = gnt_valid && m_write[gnt];
    assign up_address = m_address[gnt];
    assign up_writedata = m_writedata[gnt];
    assign up_byteenable = m_byteenable[gnt];

    // Responses return in order, so the FIFO head names their owner
    assign id_head = id_mem[id_rd_ptr];
    assign id_push = accept && up_read;
    assign id_pop = up_readdatavalid;

    always_comb
    begin
        for (int i = 0; i < N_MASTERS; i++)
        begin
            m_waitrequest[i] = up_waitrequest || !gnt_valid || (gnt != ID_W'(i));
            m_readdata[i] = up_readdata;
            m_readdatavalid[i] = up_readdatavalid && (id_head == ID_W'(i));
        end
    end

    // Priority moves past the master that was just served
    always_ff @(posedge mem_slave)
    begin
        if (reset)
            prio <= '0;
        else if (accept)
            prio <= (gnt == ID_W'(N_MASTERS - 1)) ? '0 : gnt + 1'b1;
    end

    always_ff @(posedge mem_slave)
    begin
        if (id_push)
            id_mem[id_wr_ptr] <= gnt;
    end

    always_ff @(posedge mem_slave)
    begin
        if (reset)
        begin
            id_wr_ptr <= '0;
            id_rd_ptr <= '0;
            id_count <= '0;
        end
        else
        begin
            if (id_push)
                id_wr_ptr <= (id_wr_ptr == PTR_W'(RESP_ID_DEPTH - 1)) ? '0 : id_wr_ptr + 1'b1;
            if (id_pop)
                id_rd_ptr <= (id_rd_ptr == PTR_W'(RESP_ID_DEPTH - 1)) ? '0 : id_rd_ptr + 1'b1;
            id_count <= id_count + CNT_W'(id_push) - CNT_W'(id_pop);
        end
    end

    // Every response downstream must belong to a read accepted here
    a_no_orphan_resp: assert property (@(posedge mem_slave) disable iff (reset)
        up_readdatavalid |-> (id_count != '0));

    a_no_id_overflow: assert property (@(posedge mem_slave) disable iff (reset)
        (id_push && !id_pop) |-> (id_count != CNT_W'(RESP_ID_DEPTH)));

endmodule

`default_nettype wire

// ==== hw/avmm_reg_stage.sv ====
// Register stage between the arbiter and the memory slave
// Requests and responses pass through N_REG_STAGES register slices
// Waitrequest has its own shift register of N_WAITREQUEST_STAGES
// and is treated as almost full, so the slave must absorb the requests
// that are still in flight when it raises it

`timescale 1ns/1ps
`default_nettype none

module avmm_reg_stage
#(
    parameter int N_REG_STAGES = 1,
    parameter int N_WAITREQUEST_STAGES = N_REG_STAGES
)
(
    input  logic                             mem_slave,
    input  logic                             reset,
    input  logic                             up_read,
    input  logic                             up_write,
    input  logic [avmm_pkg::ADDR_WIDTH-1:0]  up_address,
    input  logic [avmm_pkg::DATA_WIDTH-1:0]  up_writedata,
    input  logic [avmm_pkg::BE_WIDTH-1:0]    up_byteenable,
    output logic                             up_waitrequest,
    output logic [avmm_pkg::DATA_WIDTH-1:0]  up_readdata,
    output logic                             up_readdatavalid,
    output logic                             dn_read,
    output logic                             dn_write,
    output logic [avmm_pkg::ADDR_WIDTH-1:0]  dn_address,
    output logic [avmm_pkg::DATA_WIDTH-1:0]  dn_writedata,
    output logic [avmm_pkg::BE_WIDTH-1:0]    dn_byteenable,
    input  logic                             dn_waitrequest,
    input  logic [avmm_pkg::DATA_WIDTH-1:0]  dn_readdata,
    input  logic                             dn_readdatavalid
);
    import avmm_pkg::*;

    // Slice 0 is nearest the upstream side for requests
    // and nearest the downstream side for responses
    logic [N_REG_STAGES-1:0]                 rd_q;
    logic [N_REG_STAGES-1:0]                 wr_q;
    logic [N_REG_STAGES-1:0][ADDR_WIDTH-1:0] addr_q;
    logic [N_REG_STAGES-1:0][DATA_WIDTH-1:0] wdata_q;
    logic [N_REG_STAGES-1:0][BE_WIDTH-1:0]   be_q;
    logic [N_REG_STAGES-1:0]                 rvalid_q;
    logic [N_REG_STAGES-1:0][DATA_WIDTH-1:0] rdata_q;
    logic [N_WAITREQUEST_STAGES-1:0]         wait_q;

    // Request strobes, qualified by the delayed waitrequest on entry
    always_ff @(posedge mem_slave)
    begin
        rd_q[0] <= up_read && !up_waitrequest;
        wr_q[0] <= up_write && !up_waitrequest;
        for (int s = 1; s < N_REG_STAGES; s++)
        begin
            rd_q[s] <= rd_q[s-1];
            wr_q[s] <= wr_q[s-1];
        end
        if (reset)
        begin
            rd_q <= '0;
            wr_q <= '0;
        end
    end

    // Request payload only matters where a strobe is set
    always_ff @(posedge mem_slave)
    begin
        addr_q[0] <= up_address;
        wdata_q[0] <= up_writedata;
        be_q[0] <= up_byteenable;
        for (int s = 1; s < N_REG_STAGES; s++)
        begin
            addr_q[s] <= addr_q[s-1];
            wdata_q[s] <= wdata_q[s-1];
            be_q[s] <= be_q[s-1];
        end
    end

    // Responses travel the other way through the same number of slices
    always_ff @(posedge mem_slave)
    begin
        rvalid_q[0] <= dn_readdatavalid;
        rdata_q[0] <= dn_readdata;
        for (int s = 1; s < N_REG_STAGES; s++)
        begin
            rvalid_q[s] <= rvalid_q[s-1];
            rdata_q[s] <= rdata_q[s-1];
        end
        if (reset)
            rvalid_q <= '0;
    end

    // dn_waitrequest enters the waitrequest shift register at bit 0
    // Filled with ones so the masters stall until the slave is up
    always_ff @(posedge mem_slave)
    begin
        wait_q[0] <= dn_waitrequest;
        for (int s = 1; s < N_WAITREQUEST_STAGES; s++)
            wait_q[s] <= wait_q[s-1];
        if (reset)
            wait_q <= '1;
    end

    assign up_waitrequest = wait_q[N_WAITREQUEST_STAGES-1];
    assign up_readdatavalid = rvalid_q[N_REG_STAGES-1];
    assign up_readdata = rdata_q[N_REG_STAGES-1];

    assign dn_read = rd_q[N_REG_STAGES-1];
    assign dn_write = wr_q[N_REG_STAGES-1];
    assign dn_address = addr_q[N_REG_STAGES-1];
    assign dn_writedata = wdata_q[N_REG_STAGES-1];
    assign dn_byteenable = be_q[N_REG_STAGES-1];

    // The arbiter forwards one master at a time, so one strobe at most
    a_rd_wr_excl: assert property (@(posedge mem_slave) disable iff (reset)
        !(dn_read && dn_write));

endmodule

`default_nettype wire

// ==== hw/mem_map_pkg.sv ====
// Sizing of the memory side of the subsystem
// Memory depth, slave request queue and its skid room, service pacing
// Register stage counts and the depth of the read routing FIFO

`default_nettype none

package mem_map_pkg;

    localparam int MEM_DEPTH = 64;

    // Stage counts of the register stage between arbiter and slave
    localparam int REG_STAGES = 2;
    localparam int WAITREQUEST_STAGES = 2;

    // The slave keeps REQ_SKID entries free for requests already in flight
    // Must cover REG_STAGES + WAITREQUEST_STAGES + 2
    localparam int REQ_QUEUE_DEPTH = 12;
    localparam int REQ_SKID = 6;

    // Cycles between two pops of the slave's request queue
    localparam int SERVICE_INTERVAL = 2;

    // Outstanding reads that the arbiter can track
    localparam int RESP_ID_DEPTH = 16;

endpackage

`default_nettype wire

// ==== hw/avmm_pkg.sv ====
// Bus shape shared by every block of the shared-memory subsystem
// Word address, data word and byte enable widths
// Number of peer masters that the arbiter serves

`default_nettype none

package avmm_pkg;

    // Word address, so one address selects a full data word
    localparam int ADDR_WIDTH = 6;

    // Data word carried by readdata and writedata
    localparam int DATA_WIDTH = 32;

    // One enable per byte lane of the data word
    localparam int BE_WIDTH = DATA_WIDTH / 8;

    // Peer masters sharing the memory
    // This sets the width of the arbiter's master-side vectors
    localparam int N_MASTERS = 2;

endpackage

`default_nettype wire
